// File: rtl/direction_finder.sv
`timescale 1ns/10ps
`include "plotter_params.svh"

module direction_finder
	import pos_pkg::*;
(
	input  coord_t   start_x,
	input  coord_t   start_y,
	input  coord_t   cur_x,
	input  coord_t   cur_y,
	input  coord_t   end_x,
	input  coord_t   end_y,
	output pos_dir_t dir
);

	// Wide enough for the product of two coordinate differences
	localparam int EXT_BITS = 2 * `COORD_BITS + 1;

	logic signed [EXT_BITS-1:0] ext_start_x;
	logic signed [EXT_BITS-1:0] ext_start_y;
	logic signed [EXT_BITS-1:0] ext_cur_x;
	logic signed [EXT_BITS-1:0] ext_cur_y;
	logic signed [EXT_BITS-1:0] ext_end_x;
	logic signed [EXT_BITS-1:0] ext_end_y;
	logic signed [EXT_BITS-1:0] dx;
	logic signed [EXT_BITS-1:0] dy;
	logic signed [EXT_BITS-1:0] lhs;
	logic signed [EXT_BITS-1:0] rhs;
	logic        [EXT_BITS-1:0] abs_lhs;
	logic        [EXT_BITS-1:0] abs_rhs;
	logic                       dx_neg;
	logic                       dy_neg;

	// Sign extension, coordinates are signed
	assign ext_start_x = EXT_BITS'(start_x);
	assign ext_start_y = EXT_BITS'(start_y);
	assign ext_cur_x   = EXT_BITS'(cur_x);
	assign ext_cur_y   = EXT_BITS'(cur_y);
	assign ext_end_x   = EXT_BITS'(end_x);
	assign ext_end_y   = EXT_BITS'(end_y);

	assign dx = ext_end_x - ext_start_x;
	assign dy = ext_end_y - ext_start_y;

	assign dx_neg = dx[EXT_BITS-1];
	assign dy_neg = dy[EXT_BITS-1];

	// Both sides of dx*(y-y0) = dy*(x-x0) at the current point
	assign lhs = dx * (ext_cur_y - ext_start_y);
	assign rhs = dy * (ext_cur_x - ext_start_x);

	assign abs_lhs = lhs[EXT_BITS-1] ? -lhs : lhs;
	assign abs_rhs = rhs[EXT_BITS-1] ? -rhs : rhs;

	always_comb begin
		if (dx == '0) begin
			// Vertical line
			dir = dy_neg ? POS_DIR_DOWN : POS_DIR_UP;
		end else if (dy == '0) begin
			// Horizontal line
			dir = dx_neg ? POS_DIR_LEFT : POS_DIR_RIGHT;
		end else begin
			// Octant picks the two candidate moves, the error picks one
			case ({dx_neg, dy_neg})
				2'b00:   dir = (abs_lhs > abs_rhs) ? POS_DIR_RIGHT : POS_DIR_UP;
				2'b01:   dir = (abs_lhs < abs_rhs) ? POS_DIR_DOWN : POS_DIR_RIGHT;
				2'b11:   dir = (abs_lhs > abs_rhs) ? POS_DIR_LEFT : POS_DIR_DOWN;
				default: dir = (abs_lhs < abs_rhs) ? POS_DIR_UP : POS_DIR_LEFT; // dx<0, dy>0
			endcase
		end
	end

endmodule : direction_finder

// File: rtl/line_cmd_fifo.sv
`timescale 1ns/10ps
`include "plotter_params.svh"

module line_cmd_fifo
	import op_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      wr,
	input  line_cmd_t wr_data,
	input  logic      rd,
	output line_cmd_t rd_data,
	output logic      full,
	output logic      empty,
	output logic      dropped
);

	localparam int DEPTH    = `CMD_FIFO_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	line_cmd_t           mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;
	logic                do_wr;
	logic                do_rd;

	// Pointer advance with wrap for any depth
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_BITS'(1);
	endfunction

	assign do_wr   = wr && !full; // Writes while full are lost
	assign do_rd   = rd && !empty;
	assign rd_data = mem[rd_ptr]; // Head visible without a read

	always_comb begin
		count_next = count;
		case ({do_wr, do_rd})
			2'b10:   count_next = count + CNT_BITS'(1);
			2'b01:   count_next = count - CNT_BITS'(1);
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			full    <= 1'b0;
			empty   <= 1'b1;
			dropped <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count   <= count_next;
			full    <= (count_next == CNT_BITS'(DEPTH)); // Flags follow the new count
			empty   <= (count_next == '0);
			dropped <= wr && full;
		end
	end

	// Handler must only pop a non-empty queue
	a_no_rd_empty: assert property (@(posedge clk) disable iff (!arst_n)
		rd |-> !empty);

	a_count_range: assert property (@(posedge clk) disable iff (!arst_n)
		count <= CNT_BITS'(DEPTH));

endmodule : line_cmd_fifo

// File: rtl/linear_op_handler.sv
`timescale 1ns/10ps
`include "plotter_params.svh"

module linear_op_handler
	import pos_pkg::*;
	import op_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      empty,
	input  line_cmd_t head,
	output logic      pop,
	input  pos_dir_t  dir,
	output coord_t    start_x,
	output coord_t    start_y,
	output coord_t    end_x,
	output coord_t    end_y,
	output coord_t    cur_x,
	output coord_t    cur_y,
	output logic      step_req,
	input  logic      step_done,
	output logic      busy,
	output logic      op_done
);

	// One extra bit so the distance to the target cannot overflow
	localparam int DIST_BITS = `COORD_BITS + 1;

	op_state_t state;

	logic                        at_end;
	logic signed [DIST_BITS-1:0] diff_x;
	logic signed [DIST_BITS-1:0] diff_y;
	logic        [DIST_BITS-1:0] dist_x;
	logic        [DIST_BITS-1:0] dist_y;

	assign at_end   = (cur_x == end_x) && (cur_y == end_y);
	assign pop      = (state == IDLE) && !empty;
	assign step_req = (state == STEP);

	// Start and target latched as the head leaves the queue
	always_ff @(posedge clk) begin
		if (pop) begin
			start_x <= cur_x;
			start_y <= cur_y;
			end_x   <= head.x;
			end_y   <= head.y;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= IDLE;
			cur_x   <= '0;
			cur_y   <= '0;
			busy    <= 1'b0;
			op_done <= 1'b0;
		end else begin
			op_done <= 1'b0;
			case (state)
				IDLE: begin
					if (pop) begin
						state <= LOAD;
						busy  <= 1'b1;
					end
				end
				LOAD: begin
					if (at_end) begin // Zero length, nothing to step
						state   <= IDLE;
						busy    <= 1'b0;
						op_done <= 1'b1;
					end else begin
						state <= STEP;
					end
				end
				STEP: begin
					// Position moves together with the request
					case (dir)
						POS_DIR_UP:    cur_y <= cur_y + coord_t'(1);
						POS_DIR_DOWN:  cur_y <= cur_y - coord_t'(1);
						POS_DIR_LEFT:  cur_x <= cur_x - coord_t'(1);
						POS_DIR_RIGHT: cur_x <= cur_x + coord_t'(1);
						default:       cur_x <= cur_x;
					endcase
					state <= WAIT;
				end
				WAIT: begin
					if (step_done) begin
						if (at_end) begin
							state   <= IDLE;
							busy    <= 1'b0;
							op_done <= 1'b1;
						end else begin
							state <= STEP;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign diff_x = DIST_BITS'(end_x) - DIST_BITS'(cur_x);
	assign diff_y = DIST_BITS'(end_y) - DIST_BITS'(cur_y);
	assign dist_x = diff_x[DIST_BITS-1] ? -diff_x : diff_x;
	assign dist_y = diff_y[DIST_BITS-1] ? -diff_y : diff_y;

	// A chosen direction must never carry the tool past the target on an axis
	a_no_overshoot: assert property (@(posedge clk) disable iff (!arst_n)
		state == STEP |=> (dist_x <= $past(dist_x)) && (dist_y <= $past(dist_y)));

endmodule : linear_op_handler

// File: rtl/op_pkg.sv
package op_pkg;

	import pos_pkg::*;

	// Queued line command, target point only
	typedef struct packed {
		coord_t x;
		coord_t y;
	} line_cmd_t;

	// Line handler states
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for a queued command
		LOAD = 2'd1, // Command latched, check for zero length
		STEP = 2'd2, // Issue one step
		WAIT = 2'd3  // Pulse and gap in progress
	} op_state_t;

endpackage : op_pkg

// File: rtl/plotter_motion_top.sv
`timescale 1ns/10ps

module plotter_motion_top
	import pos_pkg::*;
	import op_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     cmd_strobe,
	input  coord_t   cmd_end_x,
	input  coord_t   cmd_end_y,
	output logic     cmd_full,
	output logic     cmd_dropped,
	output logic     busy,
	output logic     op_done,
	output coord_t   cur_x,
	output coord_t   cur_y,
	output logic     step_pulse,
	output pos_dir_t step_dir
);

	line_cmd_t wr_cmd;
	line_cmd_t head;
	logic      empty;
	logic      pop;
	logic      step_req;
	logic      step_done;
	pos_dir_t  dir;
	coord_t    start_x;
	coord_t    start_y;
	coord_t    end_x;
	coord_t    end_y;

	assign wr_cmd = '{x: cmd_end_x, y: cmd_end_y};

	line_cmd_fifo u_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr      (cmd_strobe),
		.wr_data (wr_cmd),
		.rd      (pop),
		.rd_data (head),
		.full    (cmd_full),
		.empty   (empty),
		.dropped (cmd_dropped)
	);

	linear_op_handler u_handler (
		.clk       (clk),
		.arst_n    (arst_n),
		.empty     (empty),
		.head      (head),
		.pop       (pop),
		.dir       (dir),
		.start_x   (start_x),
		.start_y   (start_y),
		.end_x     (end_x),
		.end_y     (end_y),
		.cur_x     (cur_x),
		.cur_y     (cur_y),
		.step_req  (step_req),
		.step_done (step_done),
		.busy      (busy),
		.op_done   (op_done)
	);

	direction_finder u_dir_finder (
		.start_x (start_x),
		.start_y (start_y),
		.cur_x   (cur_x),
		.cur_y   (cur_y),
		.end_x   (end_x),
		.end_y   (end_y),
		.dir     (dir)
	);

	step_pulse_gen u_pulse_gen (
		.clk        (clk),
		.arst_n     (arst_n),
		.step_req   (step_req),
		.dir        (dir),
		.step_pulse (step_pulse),
		.step_dir   (step_dir),
		.step_done  (step_done)
	);

endmodule : plotter_motion_top

// File: rtl/plotter_params.svh
`ifndef PLOTTER_PARAMS_SVH
`define PLOTTER_PARAMS_SVH

// Width of one signed coordinate, one byte
`define COORD_BITS 8

// Line commands that can wait in the queue
`define CMD_FIFO_DEPTH 4

// Step pulse high time in clock cycles
`define STEP_PULSE_CYCLES 3

// Low cycles after each pulse before the next step may start
`define STEP_GAP_CYCLES 2

`endif

// File: rtl/pos_pkg.sv
`include "plotter_params.svh"

package pos_pkg;

	// Signed tool coordinate
	typedef logic signed [`COORD_BITS-1:0] coord_t;

	// Unit move along one axis
	typedef enum logic [1:0] {
		POS_DIR_UP    = 2'd0, // +y
		POS_DIR_DOWN  = 2'd1, // -y
		POS_DIR_LEFT  = 2'd2, // -x
		POS_DIR_RIGHT = 2'd3  // +x
	} pos_dir_t;

endpackage : pos_pkg

// File: rtl/step_pulse_gen.sv
`timescale 1ns/10ps
`include "plotter_params.svh"

module step_pulse_gen
	import pos_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     step_req,
	input  pos_dir_t dir,
	output logic     step_pulse,
	output pos_dir_t step_dir,
	output logic     step_done
);

	localparam int PULSE    = `STEP_PULSE_CYCLES;
	localparam int GAP      = `STEP_GAP_CYCLES;
	localparam int CNT_BITS = $clog2(PULSE + GAP + 1);

	logic [CNT_BITS-1:0] cnt; // Cycles left in pulse plus gap
	logic                active;

	assign active     = (cnt != '0);
	assign step_pulse = (cnt > CNT_BITS'(GAP)); // Upper counts are the pulse phase
	assign step_done  = (cnt == CNT_BITS'(1));  // Last gap cycle

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt      <= '0;
			step_dir <= POS_DIR_UP;
		end else if (step_req) begin
			cnt      <= CNT_BITS'(PULSE + GAP);
			step_dir <= dir; // Direction set up with the rising pulse
		end else if (active) begin
			cnt <= cnt - CNT_BITS'(1);
		end
	end

	// Handler must wait for step_done before the next request
	a_no_req_active: assert property (@(posedge clk) disable iff (!arst_n)
		step_req |-> !active);

	a_dir_stable: assert property (@(posedge clk) disable iff (!arst_n)
		step_pulse && $past(step_pulse) |-> $stable(step_dir));

endmodule : step_pulse_gen

// File: run.sh
#!/bin/sh
# Build and run the plotter motion testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_plotter_motion -o sim_plotter \
	&& ./obj_dir/sim_plotter > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1

// File: src.f
+incdir+rtl
rtl/pos_pkg.sv
rtl/op_pkg.sv
rtl/line_cmd_fifo.sv
rtl/direction_finder.sv
rtl/step_pulse_gen.sv
rtl/linear_op_handler.sv
rtl/plotter_motion_top.sv
testbench/tb_plotter_motion.sv

// File: testbench/tb_plotter_motion.sv
`timescale 1ns/10ps
`include "plotter_params.svh"

module tb_plotter_motion
	import pos_pkg::*;
	import op_pkg::*;
();

	logic     clk;
	logic     arst_n;
	logic     cmd_strobe;
	coord_t   cmd_end_x;
	coord_t   cmd_end_y;
	logic     cmd_full;
	logic     cmd_dropped;
	logic     busy;
	logic     op_done;
	coord_t   cur_x;
	coord_t   cur_y;
	logic     step_pulse;
	pos_dir_t step_dir;

	int       step_errors = 0; // Per-step and pulse checks
	int       op_errors   = 0; // Completion, queue and level checks
	string    test_name   = "reset";
	bit [31:0] lcg_state  = 32'h3be0;
	int       tgt_x[$];
	int       tgt_y[$];
	int       q_x[$];       // Model of the queued targets
	int       q_y[$];
	int       m_sx, m_sy, m_cx, m_cy, m_ex, m_ey;
	int       m_steps, hi_cnt, lo_cnt, drop_cnt, done_cnt, pulse_cnt;
	int       budget_cycles;
	int       state_cycles[4];
	bit       full_seen;
	pos_dir_t exp_dir;
	pos_dir_t last_dir = POS_DIR_UP;

	plotter_motion_top uut (
		.clk(clk), .arst_n(arst_n), .cmd_strobe(cmd_strobe),
		.cmd_end_x(cmd_end_x), .cmd_end_y(cmd_end_y), .cmd_full(cmd_full),
		.cmd_dropped(cmd_dropped), .busy(busy), .op_done(op_done),
		.cur_x(cur_x), .cur_y(cur_y), .step_pulse(step_pulse), .step_dir(step_dir)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[23:16]);
	endfunction

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int max_int(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// Stepping rule that keeps the path nearest to the ideal line
	function automatic pos_dir_t exp_direction(input int sx, sy, cx, cy, ex, ey);
		int dx, dy, l, r;
		dx = ex - sx;
		dy = ey - sy;
		l  = abs_int(dx * (cy - sy));
		r  = abs_int(dy * (cx - sx));
		if (dx == 0) return (dy < 0) ? POS_DIR_DOWN : POS_DIR_UP;
		if (dy == 0) return (dx < 0) ? POS_DIR_LEFT : POS_DIR_RIGHT;
		if (dx > 0 && dy > 0) return (l > r) ? POS_DIR_RIGHT : POS_DIR_UP;
		if (dx > 0) return (l < r) ? POS_DIR_DOWN : POS_DIR_RIGHT;
		if (dy < 0) return (l > r) ? POS_DIR_LEFT : POS_DIR_DOWN;
		return (l < r) ? POS_DIR_UP : POS_DIR_LEFT;
	endfunction

	function automatic int line_error(input int sx, sy, ex, ey, cx, cy);
		return abs_int((ex - sx) * (cy - sy) - (ey - sy) * (cx - sx));
	endfunction

	always_comb exp_dir = exp_direction(m_sx, m_sy, m_cx, m_cy, m_ex, m_ey);

	// Reference model of queue, position and pulse timing
	always @(posedge clk) begin
		if (cmd_strobe && q_x.size() < `CMD_FIFO_DEPTH) begin
			q_x.push_back(int'(cmd_end_x));
			q_y.push_back(int'(cmd_end_y));
		end
		if (uut.pop && q_x.size() > 0) begin
			m_sx    <= m_cx;
			m_sy    <= m_cy;
			m_ex    <= q_x.pop_front();
			m_ey    <= q_y.pop_front();
			m_steps <= 0;
		end
		if (uut.step_req) begin
			case (exp_dir)
				POS_DIR_UP:    m_cy <= m_cy + 1;
				POS_DIR_DOWN:  m_cy <= m_cy - 1;
				POS_DIR_LEFT:  m_cx <= m_cx - 1;
				default:       m_cx <= m_cx + 1;
			endcase
			m_steps  <= m_steps + 1;
			last_dir <= exp_dir;
		end
		hi_cnt    <= step_pulse ? hi_cnt + 1 : 0;
		lo_cnt    <= step_pulse ? 0 : lo_cnt + 1;
		drop_cnt  <= drop_cnt + int'(cmd_dropped);
		done_cnt  <= done_cnt + int'(op_done);
		pulse_cnt <= pulse_cnt + int'(step_pulse && hi_cnt == 0);
		full_seen <= full_seen | cmd_full;
		state_cycles[uut.u_handler.state] <= state_cycles[uut.u_handler.state] + 1;
	end

	a_dir: assert property (@(posedge clk) disable iff (!arst_n)
		uut.step_req |-> uut.dir == exp_dir)
		else begin
			step_errors++;
			$display("FAIL %s dir expected %0d actual %0d", test_name, exp_dir, uut.dir);
		end

	a_step_dir: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(step_pulse) |-> step_dir == last_dir)
		else begin
			step_errors++;
			$display("FAIL %s step_dir expected %0d actual %0d", test_name, last_dir, step_dir);
		end

	a_cur_x: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(step_pulse) |-> int'(cur_x) == m_cx && int'(cur_y) == m_cy)
		else begin
			step_errors++;
			$display("FAIL %s cur expected (%0d,%0d) actual (%0d,%0d)",
				test_name, m_cx, m_cy, cur_x, cur_y);
		end

	// Distance from the ideal line stays within one unit step
	a_track: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(step_pulse) |->
			line_error(m_sx, m_sy, m_ex, m_ey, int'(cur_x), int'(cur_y))
				<= max_int(abs_int(m_ex - m_sx), abs_int(m_ey - m_sy)))
		else begin
			step_errors++;
			$display("FAIL %s line error expected at most %0d actual %0d", test_name,
				max_int(abs_int(m_ex - m_sx), abs_int(m_ey - m_sy)),
				line_error(m_sx, m_sy, m_ex, m_ey, int'(cur_x), int'(cur_y)));
		end

	a_done_pos: assert property (@(posedge clk) disable iff (!arst_n)
		op_done |-> int'(cur_x) == m_ex && int'(cur_y) == m_ey && !busy)
		else begin
			op_errors++;
			$display("FAIL %s final cur expected (%0d,%0d) actual (%0d,%0d)",
				test_name, m_ex, m_ey, cur_x, cur_y);
		end

	a_done_steps: assert property (@(posedge clk) disable iff (!arst_n)
		op_done |-> m_steps == abs_int(m_ex - m_sx) + abs_int(m_ey - m_sy))
		else begin
			op_errors++;
			$display("FAIL %s step count expected %0d actual %0d", test_name,
				abs_int(m_ex - m_sx) + abs_int(m_ey - m_sy), m_steps);
		end

	a_pulse_hi: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(step_pulse) |-> hi_cnt == `STEP_PULSE_CYCLES)
		else begin
			step_errors++;
			$display("FAIL %s pulse width expected %0d actual %0d", test_name,
				`STEP_PULSE_CYCLES, hi_cnt);
		end

	a_pulse_gap: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(step_pulse) |-> lo_cnt >= `STEP_GAP_CYCLES)
		else begin
			step_errors++;
			$display("Pulse gap of %0d cycles is too short in %s", lo_cnt, test_name);
		end

	a_dir_hold: assert property (@(posedge clk) disable iff (!arst_n)
		step_pulse && $past(step_pulse) |-> $stable(step_dir))
		else begin
			step_errors++;
			$display("step_dir changed while step_pulse was high in %s", test_name);
		end

	task automatic check_value(input string name, input int exp, input int act);
		assert (exp == act)
			else begin
				op_errors++;
				$display("FAIL %s expected %0d actual %0d", name, exp, act);
			end
	endtask

	task automatic send_cmd(input int x, input int y);
		@(posedge clk);
		#1;
		cmd_strobe = 1'b1;
		cmd_end_x  = coord_t'(x);
		cmd_end_y  = coord_t'(y);
		@(posedge clk);
		#1;
		cmd_strobe = 1'b0;
	endtask

	task automatic wait_done();
		forever begin
			@(posedge clk);
			#1;
			if (op_done) break;
		end
	endtask

	task automatic run_line(input string name, input int idx);
		test_name = name;
		send_cmd(tgt_x[idx], tgt_y[idx]);
		wait_done();
	endtask

	// Target list, chained from the origin, and the matching time budget
	task automatic build_targets();
		int px, py, mx, my;
		tgt_x = '{10, 10, -5, -5};
		tgt_y = '{0, -7, -7, 0};
		px = -5;
		py = 0;
		for (int i = 0; i < 8; i++) begin
			mx = (lcg_next() % 20) + 1;
			my = (lcg_next() % 20) + 1;
			px = px + (((i % 4) < 2) ? mx : -mx);
			py = py + (((i % 4) == 0 || (i % 4) == 3) ? my : -my);
			tgt_x.push_back(px);
			tgt_y.push_back(py);
		end
		tgt_x.push_back(px + 12); // Long line that keeps the handler busy
		tgt_y.push_back(py);
		for (int i = 0; i < 5; i++) begin
			tgt_x.push_back(px + (lcg_next() % 17) - 8);
			tgt_y.push_back(py + (lcg_next() % 17) - 8);
		end
		tgt_x.push_back(tgt_x[16]); // Zero length, ends where the last accepted line did
		tgt_y.push_back(tgt_y[16]);
		px = 0;
		py = 0;
		budget_cycles = 0;
		foreach (tgt_x[i]) begin
			budget_cycles += (abs_int(tgt_x[i] - px) + abs_int(tgt_y[i] - py)) * 6 + 20;
			px = tgt_x[i];
			py = tgt_y[i];
		end
	endtask

	initial begin
		arst_n     = 1'b0;
		cmd_strobe = 1'b0;
		cmd_end_x  = '0;
		cmd_end_y  = '0;
		build_targets();
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_value("reset busy", 0, int'(busy));
		check_value("reset step_pulse", 0, int'(step_pulse));
		check_value("reset cur_x", 0, int'(cur_x));
		check_value("reset cur_y", 0, int'(cur_y));
		for (int i = 0; i < 4; i++) run_line("axis line", i);
		for (int i = 4; i < 12; i++) run_line("diagonal line", i);
		test_name = "queue";
		send_cmd(tgt_x[12], tgt_y[12]);
		repeat (4) @(posedge clk);
		#1;
		for (int i = 13; i < 18; i++) begin
			cmd_strobe = 1'b1;
			cmd_end_x  = coord_t'(tgt_x[i]);
			cmd_end_y  = coord_t'(tgt_y[i]);
			@(posedge clk);
			#1;
		end
		cmd_strobe = 1'b0;
		repeat (5) wait_done();
		@(posedge clk); // Let the op_done counter take the last pulse
		#1;
		check_value("queue full seen", 1, int'(full_seen));
		check_value("queue drops", 1, drop_cnt);
		check_value("queue op_done count", 12 + 5, done_cnt);
		begin
			int pulses_before;
			pulses_before = pulse_cnt;
			run_line("zero length", 18);
			repeat (3) @(posedge clk);
			#1;
			check_value("zero length pulses", pulses_before, pulse_cnt);
		end
		check_value("idle busy", 0, int'(busy));
		$display("State cycles IDLE %0d LOAD %0d STEP %0d WAIT %0d",
			state_cycles[IDLE], state_cycles[LOAD], state_cycles[STEP], state_cycles[WAIT]);
		$display("Errors: %0d step, %0d operation", step_errors, op_errors);
		if (step_errors == 0 && op_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog sized from the command lengths
	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles + 200) @(posedge clk);
		$display("Timeout: the commands did not finish within %0d cycles", budget_cycles + 200);
		$display("Result: FAILED");
		$finish;
	end

endmodule : tb_plotter_motion
